//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
LINT     = --lint-only --timing --assert
TOP      = ex_stage_tb
FILELIST = sources.f
BUILD    = obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

# Pass only when the simulation prints the pass line
run: build
	@out="$$(./$(BUILD)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASSED"

lint:
	$(TOOL) $(LINT) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD)

//--- source/ex_byte_slice.sv
`default_nettype none

module ex_byte_slice (
  input  ex_dp_pkg::byte_t      a_i,
  input  ex_dp_pkg::byte_t      b_i,        // Already inverted for subtract
  input  ex_isa_pkg::slice_fn_t fn_i,
  input  logic                  boundary_i, // Slice starts a lane
  input  logic                  lane_cin_i,
  input  logic                  carry_i,    // From lower slice
  output ex_dp_pkg::byte_t      result_o,
  output logic                  carry_o,
  output logic                  zero_o
);

  logic                         cin;
  logic [ex_dp_pkg::BYTE_W:0]   sum; // Extra bit holds carry-out

  //////////////////////////////////////////////////
  // Adder
  //////////////////////////////////////////////////
  // Lane start cuts the chain from below
  assign cin = boundary_i ? lane_cin_i : carry_i;

  assign sum = {1'b0, a_i} + {1'b0, b_i} + {{ex_dp_pkg::BYTE_W{1'b0}}, cin};

  assign carry_o = sum[ex_dp_pkg::BYTE_W];

  // Zero of the adder byte only, used for EQ and NE
  assign zero_o = (sum[ex_dp_pkg::BYTE_W-1:0] == '0);

  //////////////////////////////////////////////////
  // Result select
  //////////////////////////////////////////////////
  always_comb begin : fn_mux
    case (fn_i)
      ex_isa_pkg::FN_AND: result_o = a_i & b_i;
      ex_isa_pkg::FN_OR:  result_o = a_i | b_i;
      ex_isa_pkg::FN_XOR: result_o = a_i ^ b_i;
      default:            result_o = sum[ex_dp_pkg::BYTE_W-1:0];
    endcase
  end

endmodule

`default_nettype wire

//--- source/ex_dp_pkg.sv
`default_nettype none

package ex_dp_pkg;

  //////////////////////////////////////////////////
  // Datapath widths
  //////////////////////////////////////////////////
  localparam int WORD_W     = 32; // Operand and result
  localparam int BYTE_W     = 8;  // One slice
  localparam int REGADDR_W  = 6;  // Register file index
  localparam int NUM_SLICES = WORD_W / BYTE_W;

  // Full operand or result word
  typedef logic [WORD_W-1:0] word_t;

  // Value handled by one slice
  typedef logic [BYTE_W-1:0] byte_t;

  // Register file write address
  typedef logic [REGADDR_W-1:0] regaddr_t;

  // One bit per byte slice
  typedef logic [NUM_SLICES-1:0] slice_mask_t;

endpackage

`default_nettype wire

//--- source/ex_isa_pkg.sv
`default_nettype none

package ex_isa_pkg;

  //////////////////////////////////////////////////
  // Encoding widths
  //////////////////////////////////////////////////
  localparam int ALU_OP_W = 4; // Operator field
  localparam int PW_W     = 2; // Pack width field
  localparam int FN_W     = 2; // Slice function field

  // ALU operator from decode
  typedef enum logic [ALU_OP_W-1:0] {
    ALU_ADD  = 4'h0,
    ALU_SUB  = 4'h1,
    ALU_AND  = 4'h2,
    ALU_OR   = 4'h3,
    ALU_XOR  = 4'h4,
    ALU_SLT  = 4'h5, // Signed less than
    ALU_SLTU = 4'h6, // Unsigned less than
    ALU_EQ   = 4'h7,
    ALU_NE   = 4'h8
  } alu_op_t;

  // Lane width for packed ADD and SUB
  typedef enum logic [PW_W-1:0] {
    PW32 = 2'b00, // One 32-bit lane
    PW16 = 2'b01, // Two 16-bit lanes
    PW8  = 2'b10  // Four 8-bit lanes
  } pack_width_t;

  // What each byte slice computes
  typedef enum logic [FN_W-1:0] {
    FN_ARITH = 2'b00, // Adder output
    FN_AND   = 2'b01,
    FN_OR    = 2'b10,
    FN_XOR   = 2'b11
  } slice_fn_t;

endpackage

`default_nettype wire

//--- source/ex_operand_decode.sv
`default_nettype none

module ex_operand_decode (
  input  ex_isa_pkg::alu_op_t                            alu_operator_i,
  input  ex_isa_pkg::pack_width_t                        pack_width_i,
  input  ex_dp_pkg::word_t                               operand_a_i,
  input  ex_dp_pkg::word_t                               operand_b_i,
  output ex_dp_pkg::byte_t [ex_dp_pkg::NUM_SLICES-1:0]   slice_a_o,
  output ex_dp_pkg::byte_t [ex_dp_pkg::NUM_SLICES-1:0]   slice_b_o,
  output ex_dp_pkg::slice_mask_t                         boundary_o,
  output logic                                           lane_cin_o,
  output ex_isa_pkg::slice_fn_t                          slice_fn_o
);

  logic                    is_cmp;   // Comparison operator
  logic                    invert_b; // Adder runs as a - b
  ex_isa_pkg::pack_width_t pw_eff;   // Width after compare override

  //////////////////////////////////////////////////
  // Operator classification
  //////////////////////////////////////////////////
  assign is_cmp = alu_operator_i inside {ex_isa_pkg::ALU_SLT, ex_isa_pkg::ALU_SLTU,
                                         ex_isa_pkg::ALU_EQ,  ex_isa_pkg::ALU_NE};

  assign invert_b = is_cmp || (alu_operator_i == ex_isa_pkg::ALU_SUB);

  // Two's complement needs the +1 at every lane start
  assign lane_cin_o = invert_b;

  always_comb begin : fn_sel
    case (alu_operator_i)
      ex_isa_pkg::ALU_AND: slice_fn_o = ex_isa_pkg::FN_AND;
      ex_isa_pkg::ALU_OR:  slice_fn_o = ex_isa_pkg::FN_OR;
      ex_isa_pkg::ALU_XOR: slice_fn_o = ex_isa_pkg::FN_XOR;
      default:             slice_fn_o = ex_isa_pkg::FN_ARITH; // Add, sub, compares
    endcase
  end

  //////////////////////////////////////////////////
  // Lane boundaries
  //////////////////////////////////////////////////
  // Compares always look at the whole word
  assign pw_eff = is_cmp ? ex_isa_pkg::PW32 : pack_width_i;

  always_comb begin : lane_mask
    case (pw_eff)
      ex_isa_pkg::PW16: boundary_o = 4'b0101; // Lanes start at bytes 0 and 2
      ex_isa_pkg::PW8:  boundary_o = 4'b1111; // Every byte its own lane
      default:          boundary_o = 4'b0001; // Single 32-bit lane
    endcase
  end

  //////////////////////////////////////////////////
  // Operand split
  //////////////////////////////////////////////////
  always_comb begin : split_operands
    for (int i = 0; i < ex_dp_pkg::NUM_SLICES; i++) begin
      slice_a_o[i] = operand_a_i[i*ex_dp_pkg::BYTE_W +: ex_dp_pkg::BYTE_W];
      // B inverted here so slices only ever add
      slice_b_o[i] = operand_b_i[i*ex_dp_pkg::BYTE_W +: ex_dp_pkg::BYTE_W]
                     ^ {ex_dp_pkg::BYTE_W{invert_b}};
    end
  end

  // Decode side must never send the spare pack width code
  always_comb begin : chk_pack_width
    assert (pack_width_i inside {ex_isa_pkg::PW32, ex_isa_pkg::PW16, ex_isa_pkg::PW8})
      else $error("ex_operand_decode: unused pack width %0h", pack_width_i);
  end

endmodule

`default_nettype wire

//--- source/ex_result_merge.sv
`default_nettype none

module ex_result_merge (
  input  ex_isa_pkg::alu_op_t                           alu_operator_i,
  input  logic                                          alu_en_i,
  input  logic                                          regfile_alu_we_i,
  input  ex_dp_pkg::regaddr_t                           regfile_alu_waddr_i,
  input  logic                                          sign_a_i,     // Operand A MSB
  input  logic                                          sign_b_i,     // Operand B MSB
  input  ex_dp_pkg::byte_t [ex_dp_pkg::NUM_SLICES-1:0]  slice_result_i,
  input  ex_dp_pkg::slice_mask_t                        slice_carry_i,
  input  ex_dp_pkg::slice_mask_t                        slice_zero_i,
  output ex_dp_pkg::word_t                              regfile_alu_wdata_fw_o,
  output ex_dp_pkg::regaddr_t                           regfile_alu_waddr_fw_o,
  output logic                                          regfile_alu_we_fw_o,
  output logic                                          branch_decision_o
);

  ex_dp_pkg::word_t word_result; // Bytes joined back together
  logic             is_cmp;
  logic             diff_sign;   // MSB of a - b
  logic             overflow;    // Signed overflow of a - b
  logic             lt_signed;
  logic             lt_unsigned;
  logic             equal;
  logic             cmp_result;

  assign word_result = slice_result_i;

  assign is_cmp = alu_operator_i inside {ex_isa_pkg::ALU_SLT, ex_isa_pkg::ALU_SLTU,
                                         ex_isa_pkg::ALU_EQ,  ex_isa_pkg::ALU_NE};

  //////////////////////////////////////////////////
  // Comparisons from the subtract
  //////////////////////////////////////////////////
  assign diff_sign = word_result[ex_dp_pkg::WORD_W-1];

  // Operands of opposite sign and result sign flipped from A
  assign overflow = (sign_a_i != sign_b_i) && (diff_sign != sign_a_i);

  assign lt_signed   = diff_sign ^ overflow;
  assign lt_unsigned = ~slice_carry_i[ex_dp_pkg::NUM_SLICES-1]; // Borrow out of the top
  assign equal       = &slice_zero_i; // Every byte of a - b zero

  always_comb begin : cmp_sel
    case (alu_operator_i)
      ex_isa_pkg::ALU_SLT:  cmp_result = lt_signed;
      ex_isa_pkg::ALU_SLTU: cmp_result = lt_unsigned;
      ex_isa_pkg::ALU_EQ:   cmp_result = equal;
      ex_isa_pkg::ALU_NE:   cmp_result = ~equal;
      default:              cmp_result = 1'b0; // No branch on plain ALU ops
    endcase
  end

  //////////////////////////////////////////////////
  // Forward port
  //////////////////////////////////////////////////
  always_comb begin : fw_data
    if (is_cmp) begin
      regfile_alu_wdata_fw_o = {{(ex_dp_pkg::WORD_W-1){1'b0}}, cmp_result};
    end else begin
      regfile_alu_wdata_fw_o = word_result;
    end
  end

  assign regfile_alu_waddr_fw_o = regfile_alu_waddr_i;
  assign regfile_alu_we_fw_o    = regfile_alu_we_i & alu_en_i; // Only with a live ALU op

  assign branch_decision_o = cmp_result;

  // Zero flags and carry chain must agree on equal operands
  always_comb begin : chk_eq_not_lt
    if (is_cmp && equal) begin
      assert (!lt_unsigned && !lt_signed)
        else $error("ex_result_merge: equal operands reported as less than");
    end
  end

endmodule

`default_nettype wire

//--- source/ex_stage_top.sv
`default_nettype none

module ex_stage_top (
  input  logic                    clk,
  input  logic                    rst_n,

  // ALU from decode
  input  ex_isa_pkg::alu_op_t     alu_operator_i,
  input  ex_isa_pkg::pack_width_t pack_width_i,
  input  ex_dp_pkg::word_t        alu_operand_a_i,
  input  ex_dp_pkg::word_t        alu_operand_b_i,
  input  logic                    alu_en_i,
  input  logic                    regfile_alu_we_i,
  input  ex_dp_pkg::regaddr_t     regfile_alu_waddr_i,

  // Load unit
  input  logic                    lsu_en_i,
  input  ex_dp_pkg::word_t        lsu_rdata_i,
  input  logic                    lsu_ready_ex_i,

  // Stall control and passthrough
  input  logic                    wb_ready_i,
  input  logic                    branch_in_ex_i,
  input  logic                    regfile_we_i,
  input  ex_dp_pkg::regaddr_t     regfile_waddr_i,

  // Forward port
  output ex_dp_pkg::word_t        regfile_alu_wdata_fw_o,
  output ex_dp_pkg::regaddr_t     regfile_alu_waddr_fw_o,
  output logic                    regfile_alu_we_fw_o,
  output logic                    branch_decision_o,

  // Writeback port
  output logic                    regfile_we_wb_o,
  output ex_dp_pkg::regaddr_t     regfile_waddr_wb_o,
  output ex_dp_pkg::word_t        regfile_wdata_wb_o,
  output logic                    ex_ready_o,
  output logic                    ex_valid_o
);

  ex_dp_pkg::byte_t [ex_dp_pkg::NUM_SLICES-1:0] slice_a;
  ex_dp_pkg::byte_t [ex_dp_pkg::NUM_SLICES-1:0] slice_b;
  ex_dp_pkg::byte_t [ex_dp_pkg::NUM_SLICES-1:0] slice_result;
  ex_dp_pkg::slice_mask_t                       boundary;
  ex_dp_pkg::slice_mask_t                       slice_zero;
  logic [ex_dp_pkg::NUM_SLICES:0]               carry_chain; // Bit i feeds slice i
  logic                                         lane_cin;
  ex_isa_pkg::slice_fn_t                        slice_fn;

  assign carry_chain[0] = 1'b0; // Nothing below byte 0

  //////////////////////////////////////////////////
  // Operand decode
  //////////////////////////////////////////////////
  ex_operand_decode u_decode (
    .alu_operator_i (alu_operator_i),
    .pack_width_i   (pack_width_i),
    .operand_a_i    (alu_operand_a_i),
    .operand_b_i    (alu_operand_b_i),
    .slice_a_o      (slice_a),
    .slice_b_o      (slice_b),
    .boundary_o     (boundary),
    .lane_cin_o     (lane_cin),
    .slice_fn_o     (slice_fn)
  );

  //////////////////////////////////////////////////
  // Byte slices with carry chain
  //////////////////////////////////////////////////
  for (genvar i = 0; i < ex_dp_pkg::NUM_SLICES; i++) begin : g_slice
    ex_byte_slice u_slice (
      .a_i        (slice_a[i]),
      .b_i        (slice_b[i]),
      .fn_i       (slice_fn),
      .boundary_i (boundary[i]),
      .lane_cin_i (lane_cin),
      .carry_i    (carry_chain[i]),
      .result_o   (slice_result[i]),
      .carry_o    (carry_chain[i+1]),
      .zero_o     (slice_zero[i])
    );
  end

  //////////////////////////////////////////////////
  // Result merge and forward port
  //////////////////////////////////////////////////
  ex_result_merge u_merge (
    .alu_operator_i         (alu_operator_i),
    .alu_en_i               (alu_en_i),
    .regfile_alu_we_i       (regfile_alu_we_i),
    .regfile_alu_waddr_i    (regfile_alu_waddr_i),
    .sign_a_i               (alu_operand_a_i[ex_dp_pkg::WORD_W-1]),
    .sign_b_i               (alu_operand_b_i[ex_dp_pkg::WORD_W-1]),
    .slice_result_i         (slice_result),
    .slice_carry_i          (carry_chain[ex_dp_pkg::NUM_SLICES:1]),
    .slice_zero_i           (slice_zero),
    .regfile_alu_wdata_fw_o (regfile_alu_wdata_fw_o),
    .regfile_alu_waddr_fw_o (regfile_alu_waddr_fw_o),
    .regfile_alu_we_fw_o    (regfile_alu_we_fw_o),
    .branch_decision_o      (branch_decision_o)
  );

  //////////////////////////////////////////////////
  // EX/WB register and stage handshake
  //////////////////////////////////////////////////
  ex_wb_pipe_reg u_pipe (
    .clk                (clk),
    .rst_n              (rst_n),
    .alu_en_i           (alu_en_i),
    .lsu_en_i           (lsu_en_i),
    .lsu_ready_ex_i     (lsu_ready_ex_i),
    .wb_ready_i         (wb_ready_i),
    .branch_in_ex_i     (branch_in_ex_i),
    .regfile_we_i       (regfile_we_i),
    .regfile_waddr_i    (regfile_waddr_i),
    .lsu_rdata_i        (lsu_rdata_i),
    .regfile_we_wb_o    (regfile_we_wb_o),
    .regfile_waddr_wb_o (regfile_waddr_wb_o),
    .regfile_wdata_wb_o (regfile_wdata_wb_o),
    .ex_ready_o         (ex_ready_o),
    .ex_valid_o         (ex_valid_o)
  );

endmodule

`default_nettype wire

//--- source/ex_wb_pipe_reg.sv
`default_nettype none

module ex_wb_pipe_reg (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                alu_en_i,
  input  logic                lsu_en_i,
  input  logic                lsu_ready_ex_i,  // Load unit done with EX part
  input  logic                wb_ready_i,      // Writeback can take data
  input  logic                branch_in_ex_i,
  input  logic                regfile_we_i,
  input  ex_dp_pkg::regaddr_t regfile_waddr_i,
  input  ex_dp_pkg::word_t    lsu_rdata_i,
  output logic                regfile_we_wb_o,
  output ex_dp_pkg::regaddr_t regfile_waddr_wb_o,
  output ex_dp_pkg::word_t    regfile_wdata_wb_o,
  output logic                ex_ready_o,      // To decode side
  output logic                ex_valid_o       // To writeback side
);

  logic                we_q;
  ex_dp_pkg::regaddr_t waddr_q;

  //////////////////////////////////////////////////
  // Handshake
  //////////////////////////////////////////////////
  // Valid flows right and ready flows left
  // Branches finish in EX so they never wait on WB
  assign ex_ready_o = (lsu_ready_ex_i & wb_ready_i) | branch_in_ex_i;
  assign ex_valid_o = (alu_en_i | lsu_en_i) & lsu_ready_ex_i & wb_ready_i;

  //////////////////////////////////////////////////
  // EX/WB register
  //////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin : ex_wb_reg
    if (!rst_n) begin
      we_q    <= 1'b0;
      waddr_q <= '0;
    end else if (ex_valid_o) begin
      we_q <= regfile_we_i;
      if (regfile_we_i) begin
        waddr_q <= regfile_waddr_i; // Keep old address on non-writing ops
      end
    end else if (wb_ready_i) begin
      we_q <= 1'b0; // Bubble out
    end
    // WB stalled so everything holds
  end

  assign regfile_we_wb_o    = we_q;
  assign regfile_waddr_wb_o = waddr_q;
  assign regfile_wdata_wb_o = lsu_rdata_i; // Load data arrives this cycle

  // A writing op lands in WB one edge later with its own address
  ast_load_to_wb: assert property (
    @(posedge clk) disable iff (!rst_n)
      ex_valid_o && regfile_we_i |=>
        regfile_we_wb_o && (regfile_waddr_wb_o == $past(regfile_waddr_i))
  ) else $error("ex_wb_pipe_reg: write did not reach writeback");

  // Back-pressure freezes the write enable
  ast_we_hold: assert property (
    @(posedge clk) disable iff (!rst_n) !wb_ready_i |=> $stable(regfile_we_wb_o)
  ) else $error("ex_wb_pipe_reg: write enable moved under back-pressure");

endmodule

`default_nettype wire

//--- sources.f
source/ex_dp_pkg.sv
source/ex_isa_pkg.sv
source/ex_operand_decode.sv
source/ex_byte_slice.sv
source/ex_result_merge.sv
source/ex_wb_pipe_reg.sv
source/ex_stage_top.sv
verification/ex_stage_tb.sv

//--- verification/ex_stage_tb.sv
`default_nettype none

module ex_stage_tb;

  localparam int MAX_CYCLES = 2000; // Tests use about 400 cycles
  localparam int ALU_PAIRS  = 40;
  localparam int PACK_PAIRS = 10;
  localparam int CMP_PAIRS  = 10;

  logic                    clk;
  logic                    rst_n;
  ex_isa_pkg::alu_op_t     alu_operator_i;
  ex_isa_pkg::pack_width_t pack_width_i;
  ex_dp_pkg::word_t        alu_operand_a_i;
  ex_dp_pkg::word_t        alu_operand_b_i;
  logic                    alu_en_i;
  logic                    regfile_alu_we_i;
  ex_dp_pkg::regaddr_t     regfile_alu_waddr_i;
  logic                    lsu_en_i;
  ex_dp_pkg::word_t        lsu_rdata_i;
  logic                    lsu_ready_ex_i;
  logic                    wb_ready_i;
  logic                    branch_in_ex_i;
  logic                    regfile_we_i;
  ex_dp_pkg::regaddr_t     regfile_waddr_i;
  ex_dp_pkg::word_t        regfile_alu_wdata_fw_o;
  ex_dp_pkg::regaddr_t     regfile_alu_waddr_fw_o;
  logic                    regfile_alu_we_fw_o;
  logic                    branch_decision_o;
  logic                    regfile_we_wb_o;
  ex_dp_pkg::regaddr_t     regfile_waddr_wb_o;
  ex_dp_pkg::word_t        regfile_wdata_wb_o;
  logic                    ex_ready_o;
  logic                    ex_valid_o;

  integer seed;              // $random state
  int     error_count  = 0;  // Failed checks
  int     tests_passed = 0;
  int     tests_failed = 0;
  int     cycle_count  = 0;

  ex_stage_top dut0 (.*);

  always #2 clk = ~clk; // Period 4

  //////////////////////////////////////////////////
  // Check and reference helpers
  //////////////////////////////////////////////////
  task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("MISMATCH %s: got 0x%08h, expected 0x%08h at %0t", name, got, exp, $time);
      error_count++;
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("MISMATCH %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
      error_count++;
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    if (error_count == errs_before) begin
      tests_passed++;
      $display("[%0t] %s: ok", $time, name);
    end else begin
      tests_failed++;
      $display("[%0t] %s: failed with %0d errors", $time, name, error_count - errs_before);
    end
  endtask

  // Per-lane wrapped add or subtract with carries dropped at lane edges
  function automatic logic [31:0] lane_arith(input logic sub, input int lw,
                                             input logic [31:0] a, input logic [31:0] b);
    logic [31:0] r;
    logic [31:0] mask;
    logic [31:0] la;
    logic [31:0] lb;
    r    = '0;
    mask = (lw == 32) ? 32'hFFFF_FFFF : ((32'd1 << lw) - 32'd1);
    for (int off = 0; off < 32; off += lw) begin
      la = (a >> off) & mask;
      lb = (b >> off) & mask;
      r  = r | (((sub ? la - lb : la + lb) & mask) << off);
    end
    return r;
  endfunction

  function automatic logic [31:0] exp_alu(input ex_isa_pkg::alu_op_t op,
                                          input ex_isa_pkg::pack_width_t pw,
                                          input logic [31:0] a, input logic [31:0] b);
    int lw;
    lw = (pw == ex_isa_pkg::PW16) ? 16 : (pw == ex_isa_pkg::PW8) ? 8 : 32;
    case (op)
      ex_isa_pkg::ALU_ADD:  return lane_arith(1'b0, lw, a, b);
      ex_isa_pkg::ALU_SUB:  return lane_arith(1'b1, lw, a, b);
      ex_isa_pkg::ALU_AND:  return a & b;
      ex_isa_pkg::ALU_OR:   return a | b;
      ex_isa_pkg::ALU_XOR:  return a ^ b;
      ex_isa_pkg::ALU_SLT:  return {31'b0, $signed(a) < $signed(b)};
      ex_isa_pkg::ALU_SLTU: return {31'b0, a < b};
      ex_isa_pkg::ALU_EQ:   return {31'b0, a == b};
      default:              return {31'b0, a != b}; // NE
    endcase
  endfunction

  task automatic drive_idle();
    alu_operator_i      = ex_isa_pkg::ALU_ADD;
    pack_width_i        = ex_isa_pkg::PW32;
    alu_operand_a_i     = '0;
    alu_operand_b_i     = '0;
    alu_en_i            = 1'b0;
    regfile_alu_we_i    = 1'b0;
    regfile_alu_waddr_i = '0;
    lsu_en_i            = 1'b0;
    lsu_rdata_i         = '0;
    lsu_ready_ex_i      = 1'b1;
    wb_ready_i          = 1'b1;
    branch_in_ex_i      = 1'b0;
    regfile_we_i        = 1'b0;
    regfile_waddr_i     = '0;
  endtask

  // One ALU op per cycle with the forward port checked before the next edge
  task automatic run_op(input ex_isa_pkg::alu_op_t op, input ex_isa_pkg::pack_width_t pw,
                        input logic [31:0] a, input logic [31:0] b);
    logic [31:0]         exp;
    logic                we;
    ex_dp_pkg::regaddr_t waddr;
    exp   = exp_alu(op, pw, a, b);
    we    = 1'($random(seed));
    waddr = ex_dp_pkg::regaddr_t'($random(seed));
    @(posedge clk);
    #1;
    alu_operator_i      = op;
    pack_width_i        = pw;
    alu_operand_a_i     = a;
    alu_operand_b_i     = b;
    alu_en_i            = 1'b1;
    regfile_alu_we_i    = we;
    regfile_alu_waddr_i = waddr;
    #2;
    check_word("regfile_alu_wdata_fw_o", regfile_alu_wdata_fw_o, exp);
    check_word("regfile_alu_waddr_fw_o", 32'(regfile_alu_waddr_fw_o), 32'(waddr));
    check_bit("regfile_alu_we_fw_o", regfile_alu_we_fw_o, we);
    if (op inside {ex_isa_pkg::ALU_SLT, ex_isa_pkg::ALU_SLTU,
                   ex_isa_pkg::ALU_EQ, ex_isa_pkg::ALU_NE}) begin
      check_bit("branch_decision_o", branch_decision_o, exp[0]);
    end
  endtask

  task automatic run_compares(input logic [31:0] a, input logic [31:0] b,
                              input ex_isa_pkg::pack_width_t pw);
    run_op(ex_isa_pkg::ALU_SLT, pw, a, b);
    run_op(ex_isa_pkg::ALU_SLTU, pw, a, b);
    run_op(ex_isa_pkg::ALU_EQ, pw, a, b);
    run_op(ex_isa_pkg::ALU_NE, pw, a, b);
  endtask

  //////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////
  task automatic test_reset();
    int errs;
    errs             = error_count;
    rst_n            = 1'b0;
    regfile_alu_we_i = 1'b1; // Must stay gated by alu_en_i
    repeat (8) @(posedge clk);
    #1;
    check_bit("regfile_we_wb_o", regfile_we_wb_o, 1'b0);
    check_word("regfile_waddr_wb_o", 32'(regfile_waddr_wb_o), 32'h0);
    repeat (8) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(posedge clk);
    #2;
    check_bit("regfile_we_wb_o", regfile_we_wb_o, 1'b0);
    check_word("regfile_waddr_wb_o", 32'(regfile_waddr_wb_o), 32'h0);
    check_bit("ex_valid_o", ex_valid_o, 1'b0);
    check_bit("regfile_alu_we_fw_o", regfile_alu_we_fw_o, 1'b0);
    report_test("reset", errs);
  endtask

  task automatic test_alu();
    int          errs;
    logic [31:0] a;
    logic [31:0] b;
    errs = error_count;
    for (int n = 0; n < ALU_PAIRS; n++) begin
      a = $random(seed);
      b = $random(seed);
      run_op(ex_isa_pkg::ALU_ADD, ex_isa_pkg::PW32, a, b);
      run_op(ex_isa_pkg::ALU_SUB, ex_isa_pkg::PW32, a, b);
      run_op(ex_isa_pkg::ALU_AND, ex_isa_pkg::PW32, a, b);
      run_op(ex_isa_pkg::ALU_OR, ex_isa_pkg::PW32, a, b);
      run_op(ex_isa_pkg::ALU_XOR, ex_isa_pkg::PW32, a, b);
    end
    report_test("alu32", errs);
  endtask

  task automatic test_packed();
    int          errs;
    logic [31:0] a;
    logic [31:0] b;
    errs = error_count;
    for (int n = 0; n < PACK_PAIRS; n++) begin
      a = $random(seed);
      b = $random(seed);
      run_op(ex_isa_pkg::ALU_ADD, ex_isa_pkg::PW16, a, b);
      run_op(ex_isa_pkg::ALU_SUB, ex_isa_pkg::PW16, a, b);
      run_op(ex_isa_pkg::ALU_ADD, ex_isa_pkg::PW8, a, b);
      run_op(ex_isa_pkg::ALU_SUB, ex_isa_pkg::PW8, a, b);
    end
    // Every lane overflows or borrows and nothing may leak upward
    run_op(ex_isa_pkg::ALU_ADD, ex_isa_pkg::PW16, 32'hFFFF_FFFF, 32'h0001_0001);
    run_op(ex_isa_pkg::ALU_ADD, ex_isa_pkg::PW16, 32'hFFFF_FFFF, 32'h0000_0001);
    run_op(ex_isa_pkg::ALU_ADD, ex_isa_pkg::PW8, 32'hFFFF_FFFF, 32'h0101_0101);
    run_op(ex_isa_pkg::ALU_SUB, ex_isa_pkg::PW16, 32'h0000_0000, 32'h0001_0001);
    run_op(ex_isa_pkg::ALU_SUB, ex_isa_pkg::PW8, 32'h0000_0000, 32'h0101_0101);
    report_test("packed", errs);
  endtask

  task automatic test_compare();
    int          errs;
    logic [31:0] a;
    logic [31:0] b;
    errs = error_count;
    for (int n = 0; n < CMP_PAIRS; n++) begin
      a = $random(seed);
      b = $random(seed);
      run_compares(a, b, ex_isa_pkg::PW32);
    end
    // Edge pairs under PW8 so the lane override is exercised too
    run_compares(32'h8000_0000, 32'h0000_0001, ex_isa_pkg::PW8);
    run_compares(32'h0000_0001, 32'h8000_0000, ex_isa_pkg::PW8);
    run_compares(32'h0000_0000, 32'h0000_0001, ex_isa_pkg::PW8); // Borrow starts in byte 0
    run_compares(a, a, ex_isa_pkg::PW8);
    run_compares(32'h0000_0000, 32'hFFFF_FFFF, ex_isa_pkg::PW8);
    run_compares(32'hFFFF_FFFF, 32'h0000_0000, ex_isa_pkg::PW16);
    report_test("compare", errs);
  endtask

  task automatic test_pipe();
    int                  errs;
    ex_dp_pkg::regaddr_t addr;
    logic [31:0]         rdata;
    errs  = error_count;
    addr  = ex_dp_pkg::regaddr_t'($random(seed)) | 6'h20; // Never the reset address
    rdata = $random(seed);
    @(posedge clk);
    #1;
    drive_idle();
    @(posedge clk); // Idle edge flushes the register
    #1;
    lsu_en_i        = 1'b1;
    regfile_we_i    = 1'b1;
    regfile_waddr_i = addr;
    lsu_rdata_i     = rdata;
    #2;
    check_bit("ex_valid_o", ex_valid_o, 1'b1);
    check_word("regfile_wdata_wb_o", regfile_wdata_wb_o, rdata);
    check_bit("regfile_we_wb_o", regfile_we_wb_o, 1'b0); // Not before the edge
    @(posedge clk);
    #1;
    wb_ready_i      = 1'b0; // Stall with a new load waiting
    regfile_waddr_i = ~addr;
    #2;
    check_bit("regfile_we_wb_o", regfile_we_wb_o, 1'b1);
    check_word("regfile_waddr_wb_o", 32'(regfile_waddr_wb_o), 32'(addr));
    check_bit("ex_valid_o", ex_valid_o, 1'b0);
    repeat (3) begin
      @(posedge clk);
      #2;
      check_bit("regfile_we_wb_o", regfile_we_wb_o, 1'b1);
      check_word("regfile_waddr_wb_o", 32'(regfile_waddr_wb_o), 32'(addr));
    end
    @(posedge clk);
    #1;
    drive_idle(); // Release with no enables
    #2;
    check_bit("regfile_we_wb_o", regfile_we_wb_o, 1'b1);
    @(posedge clk);
    #2;
    check_bit("regfile_we_wb_o", regfile_we_wb_o, 1'b0);
    check_word("regfile_waddr_wb_o", 32'(regfile_waddr_wb_o), 32'(addr));
    report_test("pipe", errs);
  endtask

  task automatic test_ready();
    int errs;
    errs = error_count;
    @(posedge clk);
    #1;
    lsu_ready_ex_i = 1'b0;
    branch_in_ex_i = 1'b0;
    #2;
    check_bit("ex_ready_o", ex_ready_o, 1'b0);
    @(posedge clk);
    #1;
    branch_in_ex_i = 1'b1; // Branch resolves in EX regardless
    #2;
    check_bit("ex_ready_o", ex_ready_o, 1'b1);
    @(posedge clk);
    #1;
    drive_idle();
    report_test("ready", errs);
  endtask

  //////////////////////////////////////////////////
  // Sequence and watchdog
  //////////////////////////////////////////////////
  initial begin : main
    clk  = 1'b0;
    seed = 32'h66a4_df00;
    drive_idle();
    test_reset();
    test_alu();
    test_packed();
    test_compare();
    test_pipe();
    test_ready();
    $display("Summary: %0d tests passed, %0d tests failed, %0d check errors",
             tests_passed, tests_failed, error_count);
    if (tests_failed == 0 && error_count == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  initial begin : watchdog
    while (cycle_count < MAX_CYCLES) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Timeout: run stopped after %0d cycles", cycle_count);
    $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire
